// File: bench/ntm_logistic_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_logistic_tb import ntm_pkg::*; ();

  localparam int NUM_TESTS = 8;
  localparam int NUM_SEG   = 18;
  // Input modes
  localparam logic [1:0] MODE_B2B   = 2'd0;
  localparam logic [1:0] MODE_GAPS  = 2'd1;
  localparam logic [1:0] MODE_WRONG = 2'd2;
  localparam logic [1:0] MODE_RAND  = 2'd3;
  // Segment corners and offsets in Q format
  localparam int ONE_Q  = 1 << `NTM_FRAC_W;
  localparam int BRK2_Q = ONE_Q * 19 / 8;
  localparam int BRK5_Q = ONE_Q * 5;
  localparam int OFF1_Q = ONE_Q / 2;
  localparam int OFF2_Q = ONE_Q * 5 / 8;
  localparam int OFF3_Q = ONE_Q * 27 / 32;

  // One table row
  // Data is base + k * step unless seg is set
  typedef struct packed {
    ntm_dims_t  dims;
    logic [1:0] mode;
    logic       seg;
    ntm_data_t  base;
    ntm_data_t  step;
  } test_t;

  // One expected result with its output cycle
  typedef struct packed {
    logic [3:0]  test;
    ntm_data_t   data;
    logic        row_end;
    logic        mat_end;
    logic [31:0] cycle;
  } exp_t;

  logic      CLK, RST, START, DATA_IN_I_ENABLE, DATA_IN_J_ENABLE;
  ntm_dims_t DIMS;
  ntm_data_t DATA_IN, DATA_OUT;
  logic      DATA_OUT_I_ENABLE, DATA_OUT_J_ENABLE, READY;

  test_t     tests [NUM_TESTS];
  string     names [NUM_TESTS];
  ntm_data_t seg_vals [NUM_SEG];
  exp_t      exp_q [$];
  int        num_tests = 0;
  int        cyc = 0;
  int        value_errs = 0;
  int        strobe_errs = 0;
  logic      table_ready = 1'b0;

  ntm_logistic_top ntm_logistic_top_inst (
    .CLK               (CLK),
    .RST               (RST),
    .START             (START),
    .DATA_IN_I_ENABLE  (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE  (DATA_IN_J_ENABLE),
    .DIMS              (DIMS),
    .DATA_IN           (DATA_IN),
    .DATA_OUT          (DATA_OUT),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .READY             (READY)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Cycle index read on the falling edge
  always @(posedge CLK) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Four-segment logistic mirrored for negative inputs
  function automatic ntm_data_t logistic_ref(input ntm_data_t x);
    int v, mag, pos;
    v   = x;
    mag = (v < 0) ? -v : v;
    if (mag < ONE_Q) pos = mag / 4 + OFF1_Q;
    else if (mag < BRK2_Q) pos = mag / 8 + OFF2_Q;
    else if (mag < BRK5_Q) pos = mag / 32 + OFF3_Q;
    else pos = ONE_Q;
    if (v < 0) pos = ONE_Q - pos;
    return ntm_data_t'(pos);
  endfunction

  task automatic add_test(input string name, input int rows, input int cols,
                          input logic [1:0] mode, input logic seg,
                          input int base, input int step);
    test_t tr;
    tr.dims.size_i = ntm_size_t'(rows);
    tr.dims.size_j = ntm_size_t'(cols);
    tr.mode        = mode;
    tr.seg         = seg;
    tr.base        = ntm_data_t'(base);
    tr.step        = ntm_data_t'(step);
    tests[num_tests] = tr;
    names[num_tests] = name;
    num_tests++;
  endtask

  // All inputs for one cycle set just after the falling edge
  task automatic drive_cycle(input logic st, input logic i_en, input logic j_en,
                             input ntm_data_t d);
    @(negedge CLK);
    START            = st;
    DATA_IN_I_ENABLE = i_en;
    DATA_IN_J_ENABLE = j_en;
    DATA_IN          = d;
  endtask

  task automatic run_test(input int t);
    int        rows, cols, k, gap;
    logic      first;
    ntm_data_t d;
    exp_t      e;
    rows = tests[t].dims.size_i;
    cols = tests[t].dims.size_j;
    // Strobe while disarmed
    if (tests[t].mode == MODE_WRONG) drive_cycle(1'b0, 1'b1, 1'b1, 16'sh1234);
    drive_cycle(1'b1, 1'b0, 1'b0, '0);
    DIMS = tests[t].dims;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        k     = r * cols + c;
        first = (c == 0);
        if (tests[t].mode == MODE_RAND) d = ntm_data_t'($urandom);
        else if (tests[t].seg) d = seg_vals[k % NUM_SEG];
        else d = tests[t].base + ntm_data_t'(k) * tests[t].step;
        if (tests[t].mode == MODE_GAPS || tests[t].mode == MODE_RAND) begin
          gap = $urandom % 4;
          repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, '0);
        end
        // J at column 0 or I mid-row
        if (tests[t].mode == MODE_WRONG && ((r + c) % 2 == 0))
          drive_cycle(1'b0, !first, first, 16'sh7fff);
        drive_cycle(1'b0, first, !first, d);
        e.test    = 4'(t);
        e.data    = logistic_ref(d);
        e.row_end = (c == cols - 1);
        e.mat_end = (c == cols - 1) && (r == rows - 1);
        e.cycle   = 32'(cyc + 2);
        exp_q.push_back(e);
      end
    end
    // Strobes after the final element
    if (tests[t].mode == MODE_WRONG) begin
      drive_cycle(1'b0, 1'b1, 1'b0, 16'sh0100);
      drive_cycle(1'b0, 1'b0, 1'b1, 16'sh0200);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin : check_results
    exp_t e;
    if (!RST) begin
      if (DATA_OUT_J_ENABLE) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected result strobe in cycle %0d", cyc);
          strobe_errs++;
        end else begin
          e = exp_q.pop_front();
          if (e.cycle != cyc) begin
            $display("** Error %s: result cycle expected %0d actual %0d",
                     names[e.test], e.cycle, cyc);
            value_errs++;
          end
          if (DATA_OUT !== e.data) begin
            $display("** Error %s: DATA_OUT expected %0d actual %0d",
                     names[e.test], e.data, DATA_OUT);
            value_errs++;
          end
          if (DATA_OUT_I_ENABLE !== e.row_end) begin
            $display("** Error %s: DATA_OUT_I_ENABLE expected %0b actual %0b",
                     names[e.test], e.row_end, DATA_OUT_I_ENABLE);
            value_errs++;
          end
          if (READY !== e.mat_end) begin
            $display("** Error %s: READY expected %0b actual %0b",
                     names[e.test], e.mat_end, READY);
            value_errs++;
          end
        end
      end else if (DATA_OUT_I_ENABLE || READY) begin
        $display("Row end or READY without a result in cycle %0d", cyc);
        strobe_errs++;
      end else if (exp_q.size() != 0) begin
        e = exp_q[0];
        if (e.cycle <= cyc) begin
          $display("Result of test %s missing in cycle %0d", names[e.test], cyc);
          strobe_errs++;
          e = exp_q.pop_front();
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST = 1'b1;
    START = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    DIMS = '0;
    DATA_IN = '0;
    void'($urandom(5));
    seg_vals = '{16'sd0, 16'sd128, -16'sd128, 16'sd255, 16'sd256, -16'sd256,
                 16'sd400, -16'sd400, 16'sd607, 16'sd608, -16'sd608, 16'sd1000,
                 -16'sd1000, 16'sd1279, 16'sd1280, -16'sd1280, 16'sd32767,
                 -16'sd32768};
    // Each row is one single-element vector
    add_test("seg_values", 18, 1, MODE_B2B, 1'b1, 0, 0);
    add_test("b2b_4x5", 4, 5, MODE_B2B, 1'b0, -1500, 157);
    add_test("single_1x1", 1, 1, MODE_B2B, 1'b0, 300, 0);
    add_test("row_1x8", 1, 8, MODE_GAPS, 1'b0, -900, 230);
    add_test("col_8x1", 8, 1, MODE_B2B, 1'b0, 1400, -350);
    add_test("wrong_strobe", 3, 4, MODE_WRONG, 1'b0, -200, 64);
    add_test("rand_gaps", 5, 6, MODE_GAPS, 1'b0, 77, 1111);
    add_test("rand_data", 6, 3, MODE_RAND, 1'b0, 0, 0);
    table_ready = 1'b1;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    // Each START follows the previous final input or a disarmed strobe directly
    for (int t = 0; t < num_tests; t++) run_test(t);
    drive_cycle(1'b0, 1'b0, 1'b0, '0);
    while (exp_q.size() != 0) @(negedge CLK);
    repeat (4) @(negedge CLK);
    $display("Errors: %0d value, %0d strobe", value_errs, strobe_errs);
    if (value_errs == 0 && strobe_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = 200;
    for (int t = 0; t < num_tests; t++)
      limit += 20 * tests[t].dims.size_i * tests[t].dims.size_j;
    repeat (limit) @(posedge CLK);
    $display("Timeout after %0d cycles, results still pending: %0d", limit, exp_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/ntm_defines.svh
`ifndef NTM_DEFINES_SVH
`define NTM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Fixed-point format
////////////////////////////////////////////////////////////////////////////

// Word width, two's complement
`define NTM_DATA_W 16
// Fraction bits, Q8.8
`define NTM_FRAC_W 8

////////////////////////////////////////////////////////////////////////////
// Matrix shape
////////////////////////////////////////////////////////////////////////////

// Largest row or column count
`define NTM_MAX_DIM 64

`endif

// File: logic/ntm_logistic_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_logistic_top import ntm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      START,
  input  logic      DATA_IN_I_ENABLE,
  input  logic      DATA_IN_J_ENABLE,
  input  ntm_dims_t DIMS,
  input  ntm_data_t DATA_IN,
  output ntm_data_t DATA_OUT,
  output logic      DATA_OUT_I_ENABLE,
  output logic      DATA_OUT_J_ENABLE,
  output logic      READY
);

  // Matrix controller
  ntm_matrix_logistic matrix_logistic_inst (
    .CLK               (CLK),
    .RST               (RST),
    .start             (START),
    .data_in_i_enable  (DATA_IN_I_ENABLE),
    .data_in_j_enable  (DATA_IN_J_ENABLE),
    .dims              (DIMS),
    .data_in           (DATA_IN),
    .data_out          (DATA_OUT),
    .data_out_i_enable (DATA_OUT_I_ENABLE),
    .data_out_j_enable (DATA_OUT_J_ENABLE),
    .ready             (READY)
  );

endmodule

`default_nettype wire

// File: logic/ntm_matrix_logistic.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_matrix_logistic import ntm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  logic      data_in_i_enable,
  input  logic      data_in_j_enable,
  input  ntm_dims_t dims,
  input  ntm_data_t data_in,
  output ntm_data_t data_out,
  output logic      data_out_i_enable,
  output logic      data_out_j_enable,
  output logic      ready
);

  // Input side state
  logic      armed;
  ntm_dims_t dims_q;
  ntm_size_t row_in;
  ntm_size_t col_in;

  logic first_col;
  logic last_col;
  logic last_row;
  logic accept;

  // Vector stage link
  logic      vec_start;
  logic      vec_in_enable;
  ntm_size_t vec_size;
  ntm_data_t vec_in;
  logic      vec_out_enable;
  ntm_elem_t vec_out;

  // Output side state
  ntm_size_t rows_done;
  ntm_size_t out_size_i;
  logic      row_end;
  logic      mat_end;

  ////////////////////////////////////////////////////////////////////////////
  // Input acceptance
  ////////////////////////////////////////////////////////////////////////////

  // I strobe only at column 0, J strobe elsewhere
  assign first_col = (col_in == '0);
  assign last_col  = (col_in == dims_q.size_j - 1'b1);
  assign last_row  = (row_in == dims_q.size_i - 1'b1);
  assign accept    = armed & (first_col ? data_in_i_enable : data_in_j_enable);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      armed  <= 1'b0;
      row_in <= '0;
      col_in <= '0;
    end else if (start) begin
      armed  <= 1'b1;
      row_in <= '0;
      col_in <= '0;
    end else if (accept) begin
      if (last_col) begin
        col_in <= '0;
        // Final element disarms, next START may follow at once
        if (last_row) begin
          armed <= 1'b0;
        end else begin
          row_in <= row_in + 1'b1;
        end
      end else begin
        col_in <= col_in + 1'b1;
      end
    end
  end

  // Shape latched at START
  always_ff @(posedge CLK) begin
    if (start) begin
      dims_q <= dims;
    end
  end

  // Row count for the output side, taken on the first element
  // so a following START does not disturb results still in flight
  always_ff @(posedge CLK) begin
    if (vec_start && (row_in == '0)) begin
      out_size_i <= dims_q.size_i;
    end
  end

  // New vector on each row's first element
  assign vec_start     = accept & first_col;
  assign vec_in_enable = accept;
  assign vec_size      = dims_q.size_j;
  assign vec_in        = data_in;

  ntm_vector_logistic vector_logistic_inst (
    .CLK        (CLK),
    .RST        (RST),
    .start      (vec_start),
    .in_enable  (vec_in_enable),
    .size       (vec_size),
    .data_in    (vec_in),
    .out_enable (vec_out_enable),
    .data_out   (vec_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Completion
  ////////////////////////////////////////////////////////////////////////////

  assign row_end = vec_out_enable & vec_out.last;
  assign mat_end = row_end & (rows_done == out_size_i - 1'b1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rows_done <= '0;
    end else if (row_end) begin
      rows_done <= mat_end ? '0 : rows_done + 1'b1;
    end
  end

  // Results leave in the cycle they appear
  assign data_out          = vec_out.data;
  assign data_out_j_enable = vec_out_enable;
  assign data_out_i_enable = row_end;
  assign ready             = mat_end;

endmodule

`default_nettype wire

// File: logic/ntm_pkg.sv
`default_nettype none

`include "ntm_defines.svh"

package ntm_pkg;

  // Size width, holds 0 up to NTM_MAX_DIM inclusive
  localparam int NTM_SIZE_W = $clog2(`NTM_MAX_DIM + 1);

  // Signed fixed-point word
  typedef logic signed [`NTM_DATA_W-1:0] ntm_data_t;

  // Element count
  typedef logic [NTM_SIZE_W-1:0] ntm_size_t;

  // Matrix shape
  typedef struct packed {
    ntm_size_t size_i;
    ntm_size_t size_j;
  } ntm_dims_t;

  // Result word with end-of-vector tag
  typedef struct packed {
    ntm_data_t data;
    logic      last;
  } ntm_elem_t;

endpackage

`default_nettype wire

// File: logic/ntm_scalar_logistic.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_scalar_logistic import ntm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      in_enable,
  input  ntm_data_t data_in,
  input  logic      last_in,
  output logic      out_enable,
  output ntm_elem_t data_out
);

  // One extra bit so that the magnitude of the most negative word fits
  localparam int MW = `NTM_DATA_W + 1;

  // Breakpoints and offsets in Q format
  localparam logic [MW-1:0] ONE_V  = MW'(1) << `NTM_FRAC_W;
  localparam logic [MW-1:0] BRK_2  = (MW'(19) << `NTM_FRAC_W) >> 3;
  localparam logic [MW-1:0] BRK_5  = MW'(5) << `NTM_FRAC_W;
  localparam logic [MW-1:0] OFF_1  = ONE_V >> 1;
  localparam logic [MW-1:0] OFF_2  = (MW'(5) << `NTM_FRAC_W) >> 3;
  localparam logic [MW-1:0] OFF_3  = (MW'(27) << `NTM_FRAC_W) >> 5;

  logic signed [MW-1:0] ext;
  logic [MW-1:0]        mag;
  logic                 neg;
  logic [MW-1:0]        pos_val;
  ntm_data_t            result;

  ////////////////////////////////////////////////////////////////////////////
  // Piecewise-linear evaluation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Sign extend, then fold to magnitude
    ext = data_in;
    neg = ext[MW-1];
    mag = neg ? -ext : ext;

    // Segment select on |x|
    if (mag < ONE_V) begin
      pos_val = (mag >> 2) + OFF_1;
    end else if (mag < BRK_2) begin
      pos_val = (mag >> 3) + OFF_2;
    end else if (mag < BRK_5) begin
      pos_val = (mag >> 5) + OFF_3;
    end else begin
      // Saturated
      pos_val = ONE_V;
    end

    // Mirror for negative inputs, 1 - f(|x|)
    if (neg) begin
      result = ntm_data_t'(ONE_V - pos_val);
    end else begin
      result = ntm_data_t'(pos_val);
    end
  end

  // Output register, one cycle latency
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_enable <= 1'b0;
      data_out   <= '0;
    end else begin
      out_enable <= in_enable;
      if (in_enable) begin
        data_out.data <= result;
        data_out.last <= last_in;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/ntm_vector_logistic.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_vector_logistic import ntm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  logic      in_enable,
  input  ntm_size_t size,
  input  ntm_data_t data_in,
  output logic      out_enable,
  output ntm_elem_t data_out
);

  // Vector length and running element index
  ntm_size_t len;
  ntm_size_t cnt;

  // Index and length seen by the current element
  ntm_size_t idx;
  ntm_size_t len_cur;
  logic      is_last;

  // Input register feeding the evaluator
  logic      sc_in_enable;
  ntm_data_t sc_in;
  logic      sc_last;

  ////////////////////////////////////////////////////////////////////////////
  // Element counting
  ////////////////////////////////////////////////////////////////////////////

  // start arrives with the first element, so bypass the stored values
  always_comb begin
    idx     = start ? '0 : cnt;
    len_cur = start ? size : len;
    is_last = (idx == len_cur - 1'b1);
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      len <= '0;
      cnt <= '0;
    end else begin
      if (start) begin
        len <= size;
        cnt <= '0;
      end
      // Wrap after the tagged element
      if (in_enable) begin
        if (is_last) begin
          cnt <= '0;
        end else begin
          cnt <= idx + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Input stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sc_in_enable <= 1'b0;
    end else begin
      sc_in_enable <= in_enable;
    end
  end

  // Word and flag travel together
  always_ff @(posedge CLK) begin
    if (in_enable) begin
      sc_in   <= data_in;
      sc_last <= is_last;
    end
  end

  // Evaluator, flag passes through unchanged
  ntm_scalar_logistic scalar_logistic_inst (
    .CLK        (CLK),
    .RST        (RST),
    .in_enable  (sc_in_enable),
    .data_in    (sc_in),
    .last_in    (sc_last),
    .out_enable (out_enable),
    .data_out   (data_out)
  );

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/ntm_pkg.sv
logic/ntm_scalar_logistic.sv
logic/ntm_vector_logistic.sv
logic/ntm_matrix_logistic.sv
logic/ntm_logistic_top.sv
bench/ntm_logistic_tb.sv
